//--- ca_pkg.sv
package ca_pkg;

   // ----------------------------------------
   // Widths with a meaning
   // ----------------------------------------
   typedef logic [9:0]  x_t;            // Column index, up to 1024 columns
   typedef logic [8:0]  y_t;            // Row index, up to 512 rows
   typedef logic        cell_t;         // One pixel, 1 is live
   typedef logic [7:0]  rule_t;         // Bit n is next state for pattern n
   typedef logic [2:0]  neighborhood_t; // Left in bit 2, right in bit 0
   typedef logic [7:0]  seed_t;         // Switch seed for the LFSR
   typedef logic [30:0] lfsr_t;         // LFSR state, output is bit 30

   // Load value for an all-zero seed
   localparam lfsr_t lfsr_default = 31'h5555_5555;

   // ----------------------------------------
   // Sweep port request, 21 bits
   // ----------------------------------------
   typedef struct packed
   {
      x_t    x;    // Column
      y_t    y;    // Row
      cell_t data; // Write data
      logic  we;   // Write enable, read otherwise
   } mem_req_t;

   // Sweep phases
   typedef enum logic [3:0]
   {
      clear,      // Zero every address
      seed_row,   // Row 0, one cell per cycle
      read_left,  // Left neighbor data valid
      read_mid,   // Middle neighbor data valid
      read_right, // Right neighbor data valid
      decide,     // Rule output valid
      write_cell, // Store the new cell
      next_cell,  // Advance cursor, issue left read
      copy_read,  // Scroll, read last row
      copy_wait,  // Scroll, data back from memory
      copy_write, // Scroll, write into row 0
      done        // Picture complete
   } sweep_state_t;

endpackage

//--- lfsr_source.sv
module lfsr_source
(
   input  logic           VGA_CTRL_CLK,
   input  logic           reset,
   input  ca_pkg::seed_t  seed,
   input  logic           rand_step,
   output ca_pkg::cell_t  rand_bit
);

   ca_pkg::lfsr_t state_q;  // Shift register
   ca_pkg::cell_t feedback; // New low bit

   // Taps at 27 and 30
   assign feedback = state_q[27] ^ state_q[30];

   always_ff @(posedge VGA_CTRL_CLK)
   begin
      if (reset)
      begin
         // Zero seed would lock up the register
         if (seed == '0)
         begin
            state_q <= ca_pkg::lfsr_default;
         end
         else
         begin
            state_q <= {seed, seed, seed, seed[7:1]}; // 8+8+8+7 bits
         end
      end
      else if (rand_step)
      begin
         state_q <= {state_q[29:0], feedback}; // One bit consumed
      end
   end

   // Bit handed out this cycle
   assign rand_bit = state_q[30];

endmodule

//--- neighborhood_decode.sv
module neighborhood_decode
#(
   parameter int grid_width = 640
)
(
   input  logic           VGA_CTRL_CLK,
   input  logic           reset,
   input  ca_pkg::cell_t  read_bit,
   input  logic           capture_left,
   input  logic           capture_mid,
   input  logic           capture_right,
   input  logic           edge_left,
   input  logic           edge_right,
   input  ca_pkg::cell_t  edge_bit,
   input  ca_pkg::rule_t  rule,
   output ca_pkg::cell_t  next_cell
);

   ca_pkg::neighborhood_t pattern; // Three cells above the cursor
   ca_pkg::rule_t         rule_q;  // Rule held from reset

   // Column index is 10 bits wide
   if (grid_width < 1 || grid_width > 1024)
   begin : g_width_check
      $error("grid_width %0d does not fit the column index", grid_width);
   end

   always_ff @(posedge VGA_CTRL_CLK)
   begin
      if (reset)
      begin
         rule_q  <= rule;    // Switches sampled once
         pattern <= '0;
      end
      else
      begin
         // Left neighbor, memory or edge
         if (capture_left)
         begin
            pattern[2] <= read_bit;
         end
         else if (edge_left)
         begin
            pattern[2] <= edge_bit;
         end
         if (capture_mid)
            pattern[1] <= read_bit;
         // Right neighbor, memory or edge
         if (capture_right)
         begin
            pattern[0] <= read_bit;
         end
         else if (edge_right)
         begin
            pattern[0] <= edge_bit;
         end
      end
   end

   // Rule table lookup
   assign next_cell = rule_q[pattern];

endmodule

//--- sweep_control.sv
module sweep_control
#(
   parameter int grid_width  = 640,
   parameter int grid_height = 480
)
(
   input  logic              VGA_CTRL_CLK,
   input  logic              reset,
   input  logic              run,
   input  logic              scroll,
   input  logic              random_top,
   input  logic              random_side,
   input  ca_pkg::cell_t     rand_bit,
   input  ca_pkg::cell_t     read_bit,
   input  ca_pkg::cell_t     next_cell,
   output ca_pkg::mem_req_t  mem_req,
   output logic              rand_step,
   output logic              capture_left,
   output logic              capture_mid,
   output logic              capture_right,
   output logic              edge_left,
   output logic              edge_right,
   output ca_pkg::cell_t     edge_bit,
   output logic              done
);

   localparam ca_pkg::x_t last_x = ca_pkg::x_t'(grid_width - 1);
   localparam ca_pkg::y_t last_y = ca_pkg::y_t'(grid_height - 1);
   localparam ca_pkg::x_t mid_x  = ca_pkg::x_t'(grid_width / 2);   // Single seed cell

   ca_pkg::sweep_state_t state;
   ca_pkg::x_t           x_q;           // Cursor column
   ca_pkg::y_t           y_q;           // Cursor row
   ca_pkg::x_t           nx;            // Cursor after this cell
   ca_pkg::y_t           ny;
   ca_pkg::y_t           up_y;          // Row above the cursor
   ca_pkg::cell_t        cell_q;        // Cell waiting to be written
   logic                 random_top_q;
   logic                 random_side_q;
   logic                 at_left;
   logic                 at_right;
   logic                 last_cell;

   // Neighbor columns clamped inside the grid
   function automatic ca_pkg::x_t left_col(ca_pkg::x_t col);
      return (col == '0) ? col : col - 1'b1;
   endfunction

   function automatic ca_pkg::x_t right_col(ca_pkg::x_t col);
      return (col == last_x) ? col : col + 1'b1;
   endfunction

   assign at_left   = (x_q == '0);
   assign at_right  = (x_q == last_x);
   assign last_cell = at_right && (y_q == last_y);
   assign nx        = at_right ? '0 : x_q + 1'b1;      // Row major walk
   assign ny        = at_right ? y_q + 1'b1 : y_q;
   assign up_y      = y_q - 1'b1;

   // ----------------------------------------
   // Phase sequencing
   // ----------------------------------------
   always_ff @(posedge VGA_CTRL_CLK)
   begin
      if (reset)
      begin
         state         <= ca_pkg::clear;
         x_q           <= '0;
         y_q           <= '0;
         random_top_q  <= random_top;
         random_side_q <= random_side;
      end
      else if (run)                          // Low run freezes everything
      begin
         unique case (state)
            ca_pkg::clear:
            begin
               x_q <= nx;
               y_q <= ny;
               if (last_cell)
               begin
                  state <= ca_pkg::seed_row;
                  x_q   <= '0;
                  y_q   <= '0;
               end
            end
            ca_pkg::seed_row:
            begin
               if (at_right)
                  state <= ca_pkg::next_cell; // Cursor wraps to row 1 there
               else
                  x_q <= nx;
            end
            ca_pkg::next_cell:
            begin
               if (last_cell)
               begin
                  state <= ca_pkg::done;
               end
               else
               begin
                  x_q   <= nx;
                  y_q   <= ny;
                  state <= ca_pkg::read_left;
               end
            end
            ca_pkg::read_left:  state <= ca_pkg::read_mid;
            ca_pkg::read_mid:   state <= ca_pkg::read_right;
            ca_pkg::read_right: state <= ca_pkg::decide;
            ca_pkg::decide:     state <= ca_pkg::write_cell;
            ca_pkg::write_cell: state <= ca_pkg::next_cell;
            ca_pkg::done:
            begin
               if (scroll)
               begin
                  state <= ca_pkg::copy_read;
                  x_q   <= '0;
               end
            end
            ca_pkg::copy_read:  state <= ca_pkg::copy_wait;
            ca_pkg::copy_wait:  state <= ca_pkg::copy_write;
            ca_pkg::copy_write:
            begin
               if (at_right)
               begin
                  y_q   <= '0;                // Next cell lands on row 1
                  state <= ca_pkg::next_cell;
               end
               else
               begin
                  x_q   <= nx;
                  state <= ca_pkg::copy_read;
               end
            end
            default: state <= ca_pkg::clear;
         endcase
      end
   end

   // Cell to write, from the rule or from the last row
   always_ff @(posedge VGA_CTRL_CLK)
   begin
      if (run && state == ca_pkg::decide)
         cell_q <= next_cell;
      else if (run && state == ca_pkg::copy_wait)
         cell_q <= read_bit;
   end

   // ----------------------------------------
   // Memory request and decode strobes
   // ----------------------------------------
   always_comb
   begin
      mem_req.x     = x_q;
      mem_req.y     = up_y;
      mem_req.data  = 1'b0;
      mem_req.we    = 1'b0;
      rand_step     = 1'b0;
      capture_left  = 1'b0;
      capture_mid   = 1'b0;
      capture_right = 1'b0;
      edge_left     = 1'b0;
      edge_right    = 1'b0;
      unique case (state)
         ca_pkg::clear:
         begin
            mem_req.y  = y_q;
            mem_req.we = run;                 // Data stays zero
         end
         ca_pkg::seed_row:
         begin
            mem_req.y    = y_q;
            mem_req.data = random_top_q ? rand_bit : (x_q == mid_x);
            mem_req.we   = run;
            rand_step    = run && random_top_q;
         end
         ca_pkg::next_cell:
         begin
            mem_req.x = left_col(nx);         // Left read for the coming cell
            mem_req.y = ny - 1'b1;
         end
         ca_pkg::read_left:
         begin
            // Frozen cycles replay the read this state needs
            mem_req.x    = run ? x_q : left_col(x_q);
            capture_left = run && !at_left;
            edge_left    = run && at_left;
            rand_step    = run && at_left && random_side_q;
         end
         ca_pkg::read_mid:
         begin
            mem_req.x   = run ? right_col(x_q) : x_q;
            capture_mid = run;
         end
         ca_pkg::read_right:
         begin
            mem_req.x     = right_col(x_q);
            capture_right = run && !at_right;
            edge_right    = run && at_right;
            rand_step     = run && at_right && random_side_q;
         end
         ca_pkg::write_cell:
         begin
            mem_req.y    = y_q;
            mem_req.data = cell_q;
            mem_req.we   = run;
         end
         ca_pkg::copy_read, ca_pkg::copy_wait:
            mem_req.y = last_y;               // Source is the bottom row
         ca_pkg::copy_write:
         begin
            mem_req.y    = '0;
            mem_req.data = cell_q;
            mem_req.we   = run;
         end
         default: ;
      endcase
   end

   assign edge_bit = random_side_q ? rand_bit : 1'b0; // Zero edges unless random
   assign done     = (state == ca_pkg::done);

endmodule

//--- frame_buffer.sv
module frame_buffer
#(
   parameter int grid_width  = 640,
   parameter int grid_height = 480
)
(
   input  logic              VGA_CTRL_CLK,
   input  ca_pkg::mem_req_t  mem_req,
   output ca_pkg::cell_t     read_bit,
   input  ca_pkg::x_t        pixel_x,
   input  ca_pkg::y_t        pixel_y,
   output ca_pkg::cell_t     pixel_bit
);

   localparam int depth  = grid_width * grid_height;
   localparam int addr_w = $clog2(depth);

   ca_pkg::cell_t     mem [depth];      // One bit per cell
   logic [addr_w-1:0] sweep_addr;
   logic [addr_w-1:0] disp_addr;
   logic              in_grid;          // Display address inside the picture
   logic              disp_ok_q;
   ca_pkg::cell_t     disp_q;           // Memory stage of display read

   // Row major addressing
   assign sweep_addr = addr_w'(mem_req.y) * addr_w'(grid_width) + addr_w'(mem_req.x);
   assign in_grid    = (32'(pixel_x) < grid_width) && (32'(pixel_y) < grid_height);
   assign disp_addr  = in_grid ? addr_w'(pixel_y) * addr_w'(grid_width) + addr_w'(pixel_x)
                               : '0;

   // Sweep port, write first
   always_ff @(posedge VGA_CTRL_CLK)
   begin
      if (mem_req.we)
      begin
         mem[sweep_addr] <= mem_req.data;
         read_bit        <= mem_req.data;
      end
      else
      begin
         read_bit <= mem[sweep_addr];
      end
   end

   // Display port, two cycles address to pixel
   always_ff @(posedge VGA_CTRL_CLK)
   begin
      disp_q    <= mem[disp_addr];
      disp_ok_q <= in_grid;
      pixel_bit <= disp_q & disp_ok_q;  // Black outside the grid
   end

endmodule

//--- ca_top.sv
module ca_top
#(
   parameter int grid_width  = 640,
   parameter int grid_height = 480
)
(
   input  logic           VGA_CTRL_CLK,
   input  logic           reset,
   input  logic           run,          // Low freezes the sweep
   input  logic           scroll,       // Pulse, taken while done
   input  ca_pkg::seed_t  seed,
   input  ca_pkg::rule_t  rule,
   input  logic           random_top,
   input  logic           random_side,
   input  ca_pkg::x_t     pixel_x,
   input  ca_pkg::y_t     pixel_y,
   output ca_pkg::cell_t  pixel_bit,
   output logic           done
);

   ca_pkg::mem_req_t mem_req;     // Sweep engine to memory
   ca_pkg::cell_t    read_bit;
   ca_pkg::cell_t    rand_bit;
   ca_pkg::cell_t    next_cell;
   ca_pkg::cell_t    edge_bit;
   logic             rand_step;
   logic             capture_left;
   logic             capture_mid;
   logic             capture_right;
   logic             edge_left;
   logic             edge_right;

   lfsr_source u_lfsr
   (
      .VGA_CTRL_CLK (VGA_CTRL_CLK),
      .reset        (reset),
      .seed         (seed),
      .rand_step    (rand_step),
      .rand_bit     (rand_bit)
   );

   // Decode, rule applied to the row above
   neighborhood_decode #(.grid_width(grid_width)) u_decode
   (
      .VGA_CTRL_CLK  (VGA_CTRL_CLK),
      .reset         (reset),
      .read_bit      (read_bit),
      .capture_left  (capture_left),
      .capture_mid   (capture_mid),
      .capture_right (capture_right),
      .edge_left     (edge_left),
      .edge_right    (edge_right),
      .edge_bit      (edge_bit),
      .rule          (rule),
      .next_cell     (next_cell)
   );

   // Execute
   sweep_control #(.grid_width(grid_width), .grid_height(grid_height)) u_sweep
   (
      .VGA_CTRL_CLK  (VGA_CTRL_CLK),
      .reset         (reset),
      .run           (run),
      .scroll        (scroll),
      .random_top    (random_top),
      .random_side   (random_side),
      .rand_bit      (rand_bit),
      .read_bit      (read_bit),
      .next_cell     (next_cell),
      .mem_req       (mem_req),
      .rand_step     (rand_step),
      .capture_left  (capture_left),
      .capture_mid   (capture_mid),
      .capture_right (capture_right),
      .edge_left     (edge_left),
      .edge_right    (edge_right),
      .edge_bit      (edge_bit),
      .done          (done)
   );

   // Result, picture store
   frame_buffer #(.grid_width(grid_width), .grid_height(grid_height)) u_frame
   (
      .VGA_CTRL_CLK (VGA_CTRL_CLK),
      .mem_req      (mem_req),
      .read_bit     (read_bit),
      .pixel_x      (pixel_x),
      .pixel_y      (pixel_y),
      .pixel_bit    (pixel_bit)
   );

endmodule

//--- tb_clock_gen.sv
module tb_clock_gen
#(
   parameter int half_period  = 50,  // Period of 100
   parameter int reset_cycles = 8
)
(
   input  logic restart,             // Request a new reset, sampled on the rising edge
   output logic VGA_CTRL_CLK,
   output logic reset
);

   logic [3:0] reset_count = 4'(reset_cycles); // Rising edges of reset still to go

   initial
   begin
      VGA_CTRL_CLK = 1'b0;
      forever #(half_period) VGA_CTRL_CLK = ~VGA_CTRL_CLK;
   end

   // Reset counts down after power up and after every restart
   always @(posedge VGA_CTRL_CLK)
   begin
      if (restart)
         reset_count <= 4'(reset_cycles);
      else if (reset_count != 4'd0)
         reset_count <= reset_count - 4'd1;
   end

   assign reset = (reset_count != 4'd0);

endmodule

//--- tb_ca_top.sv
module tb_ca_top;

   localparam int grid_width   = 32;
   localparam int grid_height  = 16;
   localparam int num_entries  = 6;
   localparam int sweep_cycles = grid_width * grid_height + grid_width
                                 + (grid_height - 1) * grid_width * 6 + 1; // Reset to done
   localparam int pause_len    = 200;
   localparam int pause_at     = sweep_cycles - pause_len / 2; // Last row, spans the finish
   localparam int stray_at     = 1200;   // Scroll pulse while done is low
   localparam ca_pkg::lfsr_t zero_seed_load = 31'h5555_5555;

   // One row of the stimulus table
   typedef struct packed
   {
      ca_pkg::rule_t rule;
      ca_pkg::seed_t seed;
      logic          random_top;
      logic          random_side;
      logic [1:0]    scrolls;       // Scrolls after the first picture
      logic          pause;         // Run low for a stretch mid sweep
      logic          stray_scroll;  // Scroll pulse before done
   } entry_t;

   logic             VGA_CTRL_CLK;
   logic             reset;
   logic             restart;
   logic             run;
   logic             scroll;
   ca_pkg::seed_t    seed;
   ca_pkg::rule_t    rule;
   logic             random_top;
   logic             random_side;
   ca_pkg::x_t       pixel_x;
   ca_pkg::y_t       pixel_y;
   ca_pkg::cell_t    pixel_bit;
   logic             done;

   entry_t           tests [num_entries];
   integer           rng_seed = 32'h54d5_aba1;
   longint           watch_limit;
   logic             limit_ready = 1'b0;

   // Reference model state
   ca_pkg::cell_t    picture [grid_height][grid_width];
   ca_pkg::lfsr_t    model_lfsr;
   ca_pkg::rule_t    model_rule;
   logic             model_side;

   tb_clock_gen u_clock
   (
      .restart      (restart),
      .VGA_CTRL_CLK (VGA_CTRL_CLK),
      .reset        (reset)
   );

   ca_top #(.grid_width(grid_width), .grid_height(grid_height)) dut
   (
      .VGA_CTRL_CLK (VGA_CTRL_CLK),
      .reset        (reset),
      .run          (run),
      .scroll       (scroll),
      .seed         (seed),
      .rule         (rule),
      .random_top   (random_top),
      .random_side  (random_side),
      .pixel_x      (pixel_x),
      .pixel_y      (pixel_y),
      .pixel_bit    (pixel_bit),
      .done         (done)
   );

   // ----------------------------------------
   // Error handling and compare tasks
   // ----------------------------------------
   task automatic abort_run();
      $display("Test failed");
      $fatal(1, "stopping at the first error");
   endtask

   task automatic check_pixel(input ca_pkg::cell_t got, input ca_pkg::cell_t expected,
                              input int x, input int y);
      if (got !== expected)
      begin
         $display("Fail pixel_bit at x=%0d y=%0d: got %h expected %h", x, y, got, expected);
         abort_run();
      end
   endtask

   task automatic check_done(input logic got, input logic expected);
      if (got !== expected)
      begin
         $display("Fail done: got %h expected %h", got, expected);
         abort_run();
      end
   endtask

   // ----------------------------------------
   // Reference model
   // ----------------------------------------
   // Hand out bit 30, shift left, feedback from taps 27 and 30
   function automatic ca_pkg::cell_t lfsr_take();
      ca_pkg::cell_t b;
      b          = model_lfsr[30];
      model_lfsr = {model_lfsr[29:0], model_lfsr[27] ^ model_lfsr[30]};
      return b;
   endfunction

   function automatic ca_pkg::cell_t side_bit();
      return model_side ? lfsr_take() : 1'b0;   // Zero edges unless random
   endfunction

   // Rows 1 onward from the row above, left edge before right edge
   task automatic compute_rows();
      ca_pkg::neighborhood_t nb;
      ca_pkg::cell_t         l;
      ca_pkg::cell_t         r;
      for (int y = 1; y < grid_height; y++)
      begin
         for (int x = 0; x < grid_width; x++)
         begin
            l = (x == 0) ? side_bit() : picture[y-1][x-1];
            r = (x == grid_width - 1) ? side_bit() : picture[y-1][x+1];
            nb = {l, picture[y-1][x], r};
            picture[y][x] = model_rule[nb];   // Bit n of the rule for pattern n
         end
      end
   endtask

   task automatic model_picture(input entry_t e);
      model_rule = e.rule;
      model_side = e.random_side;
      model_lfsr = (e.seed == 8'h00) ? zero_seed_load : {e.seed, e.seed, e.seed, e.seed[7:1]};
      for (int x = 0; x < grid_width; x++)
         picture[0][x] = e.random_top ? lfsr_take() : ca_pkg::cell_t'(x == grid_width / 2);
      compute_rows();
   endtask

   task automatic model_scroll();
      for (int x = 0; x < grid_width; x++)
         picture[0][x] = picture[grid_height-1][x];   // Last row becomes the seed
      compute_rows();                                   // LFSR keeps running
   endtask

   // ----------------------------------------
   // Stimulus
   // ----------------------------------------
   task automatic apply_reset(input entry_t e);
      @(negedge VGA_CTRL_CLK);
      rule        = e.rule;
      seed        = e.seed;
      random_top  = e.random_top;
      random_side = e.random_side;
      run         = 1'b1;
      scroll      = 1'b0;
      restart     = 1'b1;
      @(negedge VGA_CTRL_CLK);
      restart = 1'b0;
      while (reset)
         @(negedge VGA_CTRL_CLK);
      check_done(done, 1'b0);                    // Clear phase just starting
   endtask

   // Watchdog bounds this wait
   task automatic sweep_until_done(input logic pause, input logic stray);
      int cycle;
      cycle = 0;
      while (done !== 1'b1)
      begin
         if (pause && cycle == pause_at)
            run = 1'b0;
         else if (pause && cycle == pause_at + pause_len)
            run = 1'b1;
         if (stray)
            scroll = (cycle == stray_at);        // One cycle pulse
         @(negedge VGA_CTRL_CLK);
         cycle++;
      end
      if (!run)
         check_done(done, 1'b0);                 // Finished while frozen
      run    = 1'b1;
      scroll = 1'b0;
   endtask

   // Address every cycle, result two cycles later
   task automatic read_picture();
      for (int i = 0; i < grid_width * grid_height + 2; i++)
      begin
         if (i >= 2)
            check_pixel(pixel_bit, picture[(i-2) / grid_width][(i-2) % grid_width],
                        (i-2) % grid_width, (i-2) / grid_width);
         if (i < grid_width * grid_height)
         begin
            pixel_x = ca_pkg::x_t'(i % grid_width);
            pixel_y = ca_pkg::y_t'(i / grid_width);
         end
         @(negedge VGA_CTRL_CLK);
      end
   endtask

   task automatic scroll_once();
      scroll = 1'b1;
      @(negedge VGA_CTRL_CLK);
      scroll = 1'b0;
      check_done(done, 1'b0);                    // Dropped on the next edge
   endtask

   task automatic run_entry(input entry_t e);
      apply_reset(e);
      model_picture(e);
      sweep_until_done(e.pause, e.stray_scroll);
      read_picture();
      for (int s = 0; s < int'(e.scrolls); s++)
      begin
         scroll_once();
         model_scroll();
         sweep_until_done(1'b0, 1'b0);
         read_picture();
      end
   endtask

   // Clear, seed, sweep, scroll and readout cycles of one entry
   function automatic longint entry_cycles(input entry_t e);
      longint pic;
      longint scr;
      longint rd;
      pic = grid_width * grid_height + grid_width + (grid_height - 1) * grid_width * 6 + 16;
      scr = 3 * grid_width + (grid_height - 1) * grid_width * 6 + 4;
      rd  = grid_width * grid_height + 2;
      return pic + rd + longint'(e.scrolls) * (scr + rd) + longint'(e.pause ? pause_len : 0);
   endfunction

   // ----------------------------------------
   // Watchdog
   // ----------------------------------------
   initial
   begin : watchdog
      wait (limit_ready);
      #(watch_limit);
      $display("Run timed out after %0d time units without finishing", watch_limit);
      abort_run();
   end

   initial
   begin : main
      logic [31:0] rnd;
      longint      total;
      restart     = 1'b0;
      run         = 1'b0;
      scroll      = 1'b0;
      seed        = '0;
      rule        = '0;
      random_top  = 1'b0;
      random_side = 1'b0;
      pixel_x     = '0;
      pixel_y     = '0;

      // rule, seed, random_top, random_side, scrolls, pause, stray_scroll
      tests[0] = '{8'd90,  8'h00, 1'b0, 1'b0, 2'd0, 1'b0, 1'b0}; // Sierpinski
      tests[1] = '{8'd30,  8'h00, 1'b1, 1'b0, 2'd1, 1'b0, 1'b0}; // Default LFSR load
      tests[2] = '{8'd110, 8'ha5, 1'b0, 1'b1, 2'd0, 1'b1, 1'b0}; // Random edges, pause
      tests[3] = '{8'd150, 8'h3c, 1'b1, 1'b1, 2'd2, 1'b0, 1'b1}; // Stray scroll
      for (int i = 4; i < num_entries; i++)
      begin
         rnd      = $random(rng_seed);
         tests[i] = '{rnd[7:0], rnd[15:8], 1'b1, 1'b1, 2'd1, 1'b1, 1'b0};
      end

      total = 0;
      for (int i = 0; i < num_entries; i++)
         total += entry_cycles(tests[i]);
      watch_limit = 2 * total * 100;
      limit_ready = 1'b1;

      for (int i = 0; i < num_entries; i++)
         run_entry(tests[i]);

      $display("Test completed successfully");
      $finish;
   end

endmodule

//--- sources.f
ca_pkg.sv
lfsr_source.sv
neighborhood_decode.sv
sweep_control.sv
frame_buffer.sv
ca_top.sv
tb_clock_gen.sv
tb_ca_top.sv

//--- Makefile
# Verilator build and run of the cellular automaton testbench

VERILATOR ?= verilator
TOP       ?= tb_ca_top
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary -j 0
PASS_TEXT ?= Test completed successfully

.PHONY: sim clean

# Build, run, and pass only if the pass line shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
